/* include/la_cfg.svh */
`ifndef LA_CFG_SVH
`define LA_CFG_SVH

`define LA_CHN_NUM 8     // probe channels
`define LA_ADDR_W  8     // ring depth is 2**LA_ADDR_W samples
`define LA_DIV_W   16    // sample divisor width

`endif

/* rtl/la_pkg.sv */
`default_nettype none

`include "la_cfg.svh"

package la_pkg;

   // trigger condition on the selected channel
   typedef enum logic [2:0] {
      LA_LOW  = 3'd0,   // level low
      LA_HIGH = 3'd1,   // level high
      LA_RISE = 3'd2,   // rising edge
      LA_FALL = 3'd3,   // falling edge
      LA_ANY  = 3'd4,   // either edge
      LA_IMM  = 3'd5    // 5..7 all fire at once
   } la_mode_e;

   // run configuration, held stable while busy
   typedef struct packed {
      logic [`LA_DIV_W-1:0]  div;       // tick every div+1 clocks
      la_mode_e              mode;
      logic [2:0]            chn_sel;
      logic [`LA_ADDR_W-1:0] pre_num;   // samples kept ahead of trigger
   } la_cfg_t;

   // synchronized probe word and its trigger flag
   typedef struct packed {
      logic [`LA_CHN_NUM-1:0] data;
      logic                   hit;
   } la_sample_t;

endpackage

`default_nettype wire

/* rtl/sample_rate_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_cfg.svh"

module sample_rate_gen (
   input  wire                  iSysClk,
   input  wire                  arst_n,
   input  wire [`LA_DIV_W-1:0]  div,
   output logic                 tick
);

   logic [`LA_DIV_W-1:0] cnt;   // clocks left until next tick

   // free-running down counter, reloads from div on expiry
   always_ff @(posedge iSysClk or negedge arst_n) begin
      if (!arst_n) begin
         cnt  <= '0;
         tick <= 1'b0;
      end else if (cnt == '0) begin
         cnt  <= div;   // period is div+1 clocks
         tick <= 1'b1;
      end else begin
         cnt  <= cnt - 1'b1;
         tick <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* rtl/trigger_detect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_cfg.svh"

module trigger_detect
   import la_pkg::*;
(
   input  wire                    iSysClk,
   input  wire                    arst_n,
   input  wire [`LA_CHN_NUM-1:0]  data_in,
   input  wire la_mode_e          mode,
   input  wire [2:0]              chn_sel,
   output la_sample_t             smp
);

   logic [`LA_CHN_NUM-1:0] sync_1;     // first stage, may go metastable
   logic [`LA_CHN_NUM-1:0] sync_2;     // safe to use from here on
   logic [`LA_CHN_NUM-1:0] prev;       // sync_2 one clock ago
   logic [`LA_CHN_NUM-1:0] rise;
   logic [`LA_CHN_NUM-1:0] fall;
   logic [`LA_CHN_NUM-1:0] any_edge;
   logic [`LA_CHN_NUM-1:0] cond;       // per-channel condition for mode
   logic                   hit;

   always_ff @(posedge iSysClk or negedge arst_n) begin
      if (!arst_n) begin
         sync_1 <= '0;
         sync_2 <= '0;
         prev   <= '0;
      end else begin
         sync_1 <= data_in;
         sync_2 <= sync_1;
         prev   <= sync_2;
      end
   end

   assign rise     =  sync_2 & ~prev;
   assign fall     = ~sync_2 &  prev;
   assign any_edge =  sync_2 ^  prev;

   always_comb begin
      case (mode)
         LA_LOW:  cond = ~sync_2;
         LA_HIGH: cond =  sync_2;
         LA_RISE: cond =  rise;
         LA_FALL: cond =  fall;
         LA_ANY:  cond =  any_edge;
         default: cond = '1;          // immediate, codes 5 to 7
      endcase
   end

   assign hit = cond[chn_sel];

   // keep the flag aligned with the word it was judged on
   always_ff @(posedge iSysClk or negedge arst_n) begin
      if (!arst_n) begin
         smp <= '0;
      end else begin
         smp.data <= sync_2;
         smp.hit  <= hit;
      end
   end

endmodule

`default_nettype wire

/* rtl/sample_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_cfg.svh"

module sample_ctrl
   import la_pkg::*;
(
   input  wire                     iSysClk,
   input  wire                     arst_n,
   input  wire                     arm,
   input  wire                     tick,
   input  wire la_sample_t         smp,
   input  wire [`LA_ADDR_W-1:0]    pre_num,
   output logic                    busy,
   output logic                    finished,
   output logic [`LA_ADDR_W-1:0]   start_addr,
   output logic                    wr_en,
   output logic [`LA_ADDR_W-1:0]   wr_addr,
   output logic [`LA_CHN_NUM-1:0]  wr_data
);

   typedef enum logic [1:0] {
      S_IDLE,   // waiting for arm
      S_PRE,    // filling the pre-trigger part
      S_WAIT,   // ring keeps turning until a hit
      S_POST    // filling the rest after the trigger
   } state_e;

   state_e                 state;
   logic [`LA_ADDR_W-1:0]  cnt;         // samples written in this phase
   logic [`LA_ADDR_W-1:0]  cnt_inc;
   logic [`LA_ADDR_W-1:0]  post_num;    // samples after the trigger one
   logic [`LA_ADDR_W-1:0]  trig_addr;
   logic                   hit_pend;    // hit since the last tick
   logic                   hit_now;

   assign busy     = (state != S_IDLE);
   assign wr_en    = busy & tick;
   assign wr_data  = smp.data;
   assign cnt_inc  = cnt + 1'b1;
   assign post_num = {`LA_ADDR_W{1'b1}} - pre_num;
   assign hit_now  = hit_pend | smp.hit;

   // sticky between ticks so short edges are not lost at low rates
   always_ff @(posedge iSysClk or negedge arst_n) begin
      if (!arst_n) begin
         hit_pend <= 1'b0;
      end else if (tick) begin
         hit_pend <= 1'b0;
      end else begin
         hit_pend <= hit_now;
      end
   end

   // ring write pointer, kept across runs
   always_ff @(posedge iSysClk or negedge arst_n) begin
      if (!arst_n) begin
         wr_addr <= '0;
      end else if (wr_en) begin
         wr_addr <= wr_addr + 1'b1;
      end
   end

   always_ff @(posedge iSysClk) begin
      if (state == S_WAIT && tick && hit_now) begin
         trig_addr <= wr_addr;   // slot of the trigger sample
      end
   end

   always_ff @(posedge iSysClk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= S_IDLE;
         cnt        <= '0;
         finished   <= 1'b0;
         start_addr <= '0;
      end else begin
         finished <= 1'b0;
         case (state)
            S_IDLE: begin
               if (arm) begin
                  cnt   <= '0;
                  state <= (pre_num == '0) ? S_WAIT : S_PRE;
               end
            end
            S_PRE: begin
               if (tick) begin
                  cnt <= cnt_inc;
                  if (cnt_inc == pre_num) begin
                     state <= S_WAIT;
                  end
               end
            end
            S_WAIT: begin
               if (tick && hit_now) begin
                  cnt <= '0;
                  if (post_num == '0) begin   // trigger sample closes the window
                     state      <= S_IDLE;
                     finished   <= 1'b1;
                     start_addr <= wr_addr - pre_num;
                  end else begin
                     state <= S_POST;
                  end
               end
            end
            S_POST: begin
               if (tick) begin
                  cnt <= cnt_inc;
                  if (cnt_inc == post_num) begin
                     state      <= S_IDLE;
                     finished   <= 1'b1;
                     start_addr <= trig_addr - pre_num;   // wraps mod depth
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/capture_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_cfg.svh"

module capture_ram (
   input  wire                     iSysClk,
   input  wire                     wr_en,
   input  wire [`LA_ADDR_W-1:0]    wr_addr,
   input  wire [`LA_CHN_NUM-1:0]   wr_data,
   input  wire [`LA_ADDR_W-1:0]    rd_addr,
   output logic [`LA_CHN_NUM-1:0]  rd_data
);

   localparam int DEPTH = 1 << `LA_ADDR_W;

   logic [`LA_CHN_NUM-1:0] mem [DEPTH];   // one word per sample

   always_ff @(posedge iSysClk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered read, data one clock after address
   always_ff @(posedge iSysClk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

/* rtl/logic_analyzer_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_cfg.svh"

module logic_analyzer_top
   import la_pkg::*;
(
   input  wire                     iSysClk,
   input  wire                     arst_n,
   input  wire                     arm,
   input  wire la_cfg_t            cfg,
   input  wire [`LA_CHN_NUM-1:0]   data_in,
   input  wire [`LA_ADDR_W-1:0]    rd_addr,
   output logic                    busy,
   output logic                    finished,
   output logic [`LA_ADDR_W-1:0]   start_addr,
   output logic [`LA_CHN_NUM-1:0]  rd_data
);

   logic                    tick;
   la_sample_t              smp;
   logic                    wr_en;
   logic [`LA_ADDR_W-1:0]   wr_addr;
   logic [`LA_CHN_NUM-1:0]  wr_data;

   sample_rate_gen i_rate (
      .iSysClk (iSysClk),
      .arst_n  (arst_n),
      .div     (cfg.div),
      .tick    (tick)
   );

   trigger_detect i_trig (
      .iSysClk (iSysClk),
      .arst_n  (arst_n),
      .data_in (data_in),
      .mode    (cfg.mode),
      .chn_sel (cfg.chn_sel),
      .smp     (smp)
   );

   sample_ctrl i_ctrl (
      .iSysClk    (iSysClk),
      .arst_n     (arst_n),
      .arm        (arm),
      .tick       (tick),
      .smp        (smp),
      .pre_num    (cfg.pre_num),
      .busy       (busy),
      .finished   (finished),
      .start_addr (start_addr),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data)
   );

   capture_ram i_ram (
      .iSysClk (iSysClk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

/* tb/tb_logic_analyzer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_cfg.svh"

module tb_logic_analyzer
   import la_pkg::*;
();

   localparam int          CLK_HALF = 4;                 // 8 ns period
   localparam int          DEPTH    = 1 << `LA_ADDR_W;
   localparam int          NUM_ROWS = 14;
   localparam int          SETTLE   = 32;                // clocks from cfg change to arm
   localparam logic [31:0] SEED     = 32'hd376_0d0c;

   // one test row, step is the expected distance between window entries
   typedef struct packed {
      logic [2:0]             mode;
      logic [2:0]             chn;
      logic [`LA_ADDR_W-1:0]  pre;
      logic [`LA_DIV_W-1:0]   div;
      logic [`LA_CHN_NUM-1:0] step;
      logic                   rearm;   // extra arm pulse while busy
   } row_t;

   logic                    iSysClk;
   logic                    arst_n;
   logic                    arm;
   la_cfg_t                 cfg;
   logic [`LA_CHN_NUM-1:0]  data_in;
   logic [`LA_ADDR_W-1:0]   rd_addr;
   logic                    busy;
   logic                    finished;
   logic [`LA_ADDR_W-1:0]   start_addr;
   logic [`LA_CHN_NUM-1:0]  rd_data;

   row_t                    tbl [NUM_ROWS];
   logic [`LA_CHN_NUM-1:0]  win [DEPTH];   // captured window, oldest first
   int                      wd_cycles;

   logic_analyzer_top i_dut (
      .iSysClk    (iSysClk),
      .arst_n     (arst_n),
      .arm        (arm),
      .cfg        (cfg),
      .data_in    (data_in),
      .rd_addr    (rd_addr),
      .busy       (busy),
      .finished   (finished),
      .start_addr (start_addr),
      .rd_data    (rd_data)
   );

   always #CLK_HALF iSysClk = ~iSysClk;

   // probe counter, every sampled word is predictable
   always @(posedge iSysClk) begin
      #1;
      data_in <= data_in + 1'b1;
   end

   task automatic step();
      @(posedge iSysClk);
      #1;   // drive and sample just after the edge
   endtask

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("** Error at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
         $display("** FAIL **");
         $fatal(1, "value mismatch");
      end
   endtask

   // trigger rule on one channel, prv is the word one clock earlier
   function automatic logic rule_met(input logic [2:0] mode,
                                     input logic [2:0] chn,
                                     input logic [`LA_CHN_NUM-1:0] cur,
                                     input logic [`LA_CHN_NUM-1:0] prv);
      logic c;
      logic p;
      c = cur[chn];
      p = prv[chn];
      case (mode)
         3'd0:    return !c;        // low level
         3'd1:    return c;         // high level
         3'd2:    return c && !p;   // rising
         3'd3:    return !c && p;   // falling
         3'd4:    return c != p;    // either edge
         default: return 1'b1;      // immediate
      endcase
   endfunction

   task automatic load_table();
      //        mode  chn   pre     div    step   rearm
      tbl[0]  = '{3'd0, 3'd2, 8'd16,  16'd0, 8'd1, 1'b1};
      tbl[1]  = '{3'd1, 3'd5, 8'd100, 16'd0, 8'd1, 1'b0};
      tbl[2]  = '{3'd2, 3'd0, 8'd0,   16'd0, 8'd1, 1'b0};
      tbl[3]  = '{3'd2, 3'd7, 8'd200, 16'd0, 8'd1, 1'b0};
      tbl[4]  = '{3'd3, 3'd3, 8'd64,  16'd0, 8'd1, 1'b0};
      tbl[5]  = '{3'd3, 3'd6, 8'd0,   16'd0, 8'd1, 1'b0};
      tbl[6]  = '{3'd4, 3'd1, 8'd128, 16'd0, 8'd1, 1'b0};
      tbl[7]  = '{3'd4, 3'd4, 8'd255, 16'd0, 8'd1, 1'b0};
      tbl[8]  = '{3'd5, 3'd0, 8'd0,   16'd0, 8'd1, 1'b0};
      tbl[9]  = '{3'd6, 3'd3, 8'd50,  16'd0, 8'd1, 1'b0};
      tbl[10] = '{3'd7, 3'd7, 8'd255, 16'd0, 8'd1, 1'b0};
      tbl[11] = '{3'd1, 3'd4, 8'd32,  16'd1, 8'd2, 1'b0};
      tbl[12] = '{3'd0, 3'd5, 8'd77,  16'd3, 8'd4, 1'b0};
      tbl[13] = '{3'd1, 3'd6, 8'd0,   16'd2, 8'd3, 1'b0};
   endtask

   // capture, trigger search, quiet window and readback per row
   function automatic int budget_cycles();
      int total;
      total = 100;   // reset and start-up
      for (int r = 0; r < NUM_ROWS; r++) begin
         total += 3 * DEPTH * (int'(tbl[r].div) + 1) + 400;
      end
      return total;
   endfunction

   task automatic watchdog();
      repeat (wd_cycles) @(posedge iSysClk);
      $display("timeout: no finished pulse arrived within %0d clocks", wd_cycles);
      $display("** FAIL **");
      $fatal(1, "watchdog expired");
   endtask

   task automatic wait_finished();
      logic done;
      done = 1'b0;
      while (!done) begin
         step();
         if (finished) begin
            check(32'(busy), 32'd0, "busy still high with finished");
            done = 1'b1;
         end else begin
            check(32'(busy), 32'd1, "busy fell before finished");
         end
      end
   endtask

   task automatic read_window(input logic [`LA_ADDR_W-1:0] base);
      rd_addr = base;
      step();
      for (int i = 0; i < DEPTH; i++) begin
         win[i]  = rd_data;            // one clock read latency
         rd_addr = rd_addr + 1'b1;     // wraps around the ring
         step();
      end
   endtask

   task automatic check_window(input row_t row);
      logic [`LA_CHN_NUM-1:0] diff;
      logic [`LA_CHN_NUM-1:0] cur;
      logic [`LA_CHN_NUM-1:0] prv;
      logic                   found;
      for (int i = 1; i < DEPTH; i++) begin
         diff = win[i] - win[i-1];
         check(32'(diff), 32'(row.step), "sample spacing in window");
      end
      cur = win[row.pre];
      if (row.div == '0 && row.pre != '0) begin
         found = rule_met(row.mode, row.chn, cur, win[row.pre - 1'b1]);
      end else begin
         // hit may come from any clock since the previous tick
         found = 1'b0;
         for (int j = 0; j <= int'(row.div); j++) begin
            prv   = cur - 1'b1;
            found = found | rule_met(row.mode, row.chn, cur, prv);
            cur   = prv;
         end
      end
      check(32'(found), 32'd1, "trigger rule at index pre_num");
   endtask

   task automatic run_row(input int r);
      row_t                   row;
      logic [`LA_CHN_NUM-1:0] arm_word;     // probe word on the edge before arm
      logic [`LA_CHN_NUM-1:0] first_word;
      row = tbl[r];
      cfg = {row.div, row.mode, row.chn, row.pre};
      repeat (SETTLE) step();
      check(32'(busy), 32'd0, "busy before arm");
      arm      = 1'b1;
      arm_word = data_in;
      step();
      arm = 1'b0;
      check(32'(busy), 32'd1, "busy after arm");
      if (row.rearm) begin
         repeat (10) step();
         check(32'(busy), 32'd1, "busy at extra arm");
         arm = 1'b1;   // must be ignored
         step();
         arm = 1'b0;
      end
      wait_finished();
      step();
      check(32'(finished), 32'd0, "finished longer than one clock");
      if (row.rearm) begin
         repeat (DEPTH * (int'(row.div) + 1) + 64) begin
            step();
            check(32'(finished), 32'd0, "second finished after arm while busy");
            check(32'(busy), 32'd0, "arm while busy started a new run");
         end
      end
      read_window(start_addr);
      check_window(row);
      if (row.mode >= 3'd5 && row.div == '0) begin
         // first write holds the word sampled one clock before arm
         first_word = arm_word - 1'b1 + row.pre;
         check(32'(win[row.pre]), 32'(first_word), "immediate trigger after pre-fill");
      end
   endtask

   initial begin
      logic [31:0] rnd;
      iSysClk = 1'b0;
      arst_n  = 1'b0;
      arm     = 1'b0;
      cfg     = '0;
      rd_addr = '0;
      rnd     = $urandom(SEED);
      rnd     = $urandom();
      data_in <= rnd[`LA_CHN_NUM-1:0];   // random counter start
      load_table();
      wd_cycles = budget_cycles();
      fork
         watchdog();
      join_none
      repeat (16) @(posedge iSysClk);
      #1;
      check(32'(busy), 32'd0, "busy in reset");
      check(32'(finished), 32'd0, "finished in reset");
      check(32'(start_addr), 32'd0, "start_addr in reset");
      arst_n = 1'b1;
      step();
      check(32'(busy), 32'd0, "busy after reset");
      check(32'(finished), 32'd0, "finished after reset");
      check(32'(start_addr), 32'd0, "start_addr after reset");
      for (int r = 0; r < NUM_ROWS; r++) begin
         run_row(r);
      end
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
rtl/la_pkg.sv
rtl/sample_rate_gen.sv
rtl/trigger_detect.sv
rtl/sample_ctrl.sv
rtl/capture_ram.sv
rtl/logic_analyzer_top.sv
tb/tb_logic_analyzer.sv

/* Makefile */
# Verilator simulation of the logic analyzer capture core

VERILATOR ?= verilator
TOP       ?= tb_logic_analyzer
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

# a $fatal in the testbench makes the binary exit non-zero
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
